// File: Bender.yml
package:
  name: serial_bus

sources:
  # packages first, then the design bottom up
  - src/bus_pkg.sv
  - src/host_pkg.sv
  - src/master_cmd_regs.sv
  - src/master_out_port.sv
  - src/master_in_port.sv
  - src/slave_port.sv
  - src/serial_bus_top.sv

  - target: simulation
    files:
      - tb/serial_bus_tb.sv

// File: src/bus_pkg.sv
// bus widths, frame lengths, opcode enum and the two line structs
package bus_pkg;

	// address and data widths carried on the wire
	localparam int ADDR_LEN = 12;
	localparam int DATA_LEN = 8;
	// frame length in bits, opcode field first
	localparam int RD_FRAME_LEN = 2 + ADDR_LEN;
	localparam int WR_FRAME_LEN = 2 + ADDR_LEN + DATA_LEN;

	// opcode, first two bits of every frame
	typedef enum logic [1:0]
	{
		op_nop   = 2'b00,
		op_write = 2'b10,
		op_read  = 2'b11
	} bus_op_e;

	// master to slave wire bundle
	typedef struct packed
	{
		logic sdo;
		logic master_valid;
		logic master_ready;
	} bus_m2s_t;

	// slave to master wire bundle
	typedef struct packed
	{
		logic sdi;
		logic slave_valid;
		logic slave_ready;
	} bus_s2m_t;

endpackage

// File: src/host_pkg.sv
// host command and response structs
package host_pkg;

	import bus_pkg::*;

	// one host command, as written into the register block
	typedef struct packed
	{
		bus_op_e             op;
		logic [ADDR_LEN-1:0] addr;
		logic [DATA_LEN-1:0] wdata;
	} host_cmd_t;

	// completion record
	// rdata zero for a write
	typedef struct packed
	{
		bus_op_e             op;
		logic [ADDR_LEN-1:0] addr;
		logic [DATA_LEN-1:0] rdata;
	} host_rsp_t;

endpackage

// File: src/master_cmd_regs.sv
// command/status registers, start pulse and response capture for the master
`timescale 1ns/10ps

module master_cmd_regs
	import bus_pkg::*, host_pkg::*;
(
	input  logic                clk,
	input  logic                reset,
	input  host_cmd_t           cmd,
	input  logic                cmd_valid,
	input  logic                tx_done,
	input  logic                rx_done,
	input  logic [DATA_LEN-1:0] rx_data,
	output host_cmd_t           cur_cmd,
	output logic                start,
	output logic                busy,
	output host_rsp_t           rsp,
	output logic                rsp_valid
);

	logic accept;
	logic done;

	// only taken while idle, nop never reaches the line
	assign accept = cmd_valid && !busy && (cmd.op != op_nop);
	// write ends with the outgoing frame
	// read ends with the returned byte
	assign done = (tx_done && (cur_cmd.op == op_write)) ||
		(rx_done && (cur_cmd.op == op_read));

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			busy      <= 1'b0;
			start     <= 1'b0;
			rsp_valid <= 1'b0;
		end
		else
		begin
			// kick the output port the cycle after acceptance
			start     <= accept;
			rsp_valid <= busy && done;
			// busy covers the rsp_valid cycle too
			if (accept)
				busy <= 1'b1;
			else if (rsp_valid)
				busy <= 1'b0;
		end
	end

	// command held stable for the whole transfer
	always_ff @(posedge clk)
	begin
		if (accept)
			cur_cmd <= cmd;
		if (done)
		begin
			rsp.op    <= cur_cmd.op;
			rsp.addr  <= cur_cmd.addr;
			rsp.rdata <= (cur_cmd.op == op_read) ? rx_data : '0;
		end
	end

endmodule

// File: src/master_in_port.sv
// master input port FSM, read data deserializer from the slave
`timescale 1ns/10ps

module master_in_port
	import bus_pkg::*, host_pkg::*;
(
	input  logic                clk,
	input  logic                reset,
	input  host_cmd_t           cur_cmd,
	input  logic                tx_done,
	input  bus_s2m_t            s2m,
	output logic                master_ready,
	output logic [DATA_LEN-1:0] data,
	output logic                rx_done
);

	localparam int CNT_W = $clog2(DATA_LEN);

	typedef enum logic [1:0]
	{
		st_idle,
		st_wait_hs,
		st_receive
	} state_e;

	state_e           state;
	logic [CNT_W-1:0] bit_cnt;
	logic             handshake;
	logic             sample;

	// first read bit, both sides ready
	assign handshake = (state == st_wait_hs) && s2m.slave_valid && master_ready;
	// one bit per cycle after the handshake
	assign sample = handshake || (state == st_receive);

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state        <= st_idle;
			bit_cnt      <= '0;
			master_ready <= 1'b1;
			rx_done      <= 1'b0;
		end
		else
		begin
			rx_done <= 1'b0;
			case (state)
				st_idle:
				begin
					// arm once the read frame has gone out
					if (tx_done && (cur_cmd.op == op_read))
					begin
						bit_cnt <= '0;
						state   <= st_wait_hs;
					end
				end
				st_wait_hs:
				begin
					if (handshake)
					begin
						bit_cnt      <= CNT_W'(1);
						master_ready <= 1'b0;
						state        <= st_receive;
					end
				end
				st_receive:
				begin
					if (bit_cnt == CNT_W'(DATA_LEN - 1))
					begin
						// last bit sampled on this edge
						bit_cnt      <= '0;
						master_ready <= 1'b1;
						rx_done      <= 1'b1;
						state        <= st_idle;
					end
					else
						bit_cnt <= bit_cnt + 1'b1;
				end
				default:
					state <= st_idle;
			endcase
		end
	end

	// LSB first, bit index follows the counter
	always_ff @(posedge clk)
	begin
		if (sample)
			data[bit_cnt] <= s2m.sdi;
	end

endmodule

// File: src/master_out_port.sv
// master output port FSM, frame serializer toward the slave
`timescale 1ns/10ps

module master_out_port
	import bus_pkg::*, host_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  host_cmd_t cur_cmd,
	input  logic      start,
	input  bus_s2m_t  s2m,
	output logic      sdo,
	output logic      master_valid,
	output logic      tx_done
);

	localparam int CNT_W = $clog2(WR_FRAME_LEN);

	typedef enum logic [1:0]
	{
		st_idle,
		st_handshake,
		st_shift
	} state_e;

	state_e                  state;
	logic [WR_FRAME_LEN-1:0] frame_sr;
	logic [CNT_W-1:0]        bit_cnt;
	logic [CNT_W-1:0]        last_bit;
	logic                    shift_en;

	// read frames stop after the address
	assign last_bit = (cur_cmd.op == op_write) ? CNT_W'(WR_FRAME_LEN - 1) :
		CNT_W'(RD_FRAME_LEN - 1);
	// line bit is always the shift register LSB
	assign sdo = frame_sr[0];
	// bit 0 moves on the handshake, the rest every cycle
	assign shift_en = ((state == st_handshake) && s2m.slave_ready) || (state == st_shift);

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state        <= st_idle;
			bit_cnt      <= '0;
			master_valid <= 1'b0;
			tx_done      <= 1'b0;
		end
		else
		begin
			tx_done <= 1'b0;
			case (state)
				st_idle:
				begin
					if (start)
					begin
						bit_cnt      <= '0;
						master_valid <= 1'b1;
						state        <= st_handshake;
					end
				end
				st_handshake:
				begin
					// hold bit 0 until the slave is free
					if (s2m.slave_ready)
					begin
						bit_cnt <= CNT_W'(1);
						state   <= st_shift;
					end
				end
				st_shift:
				begin
					if (bit_cnt == last_bit)
					begin
						// last bit leaves on this edge
						master_valid <= 1'b0;
						tx_done      <= 1'b1;
						state        <= st_idle;
					end
					else
						bit_cnt <= bit_cnt + 1'b1;
				end
				default:
					state <= st_idle;
			endcase
		end
	end

	// frame layout, LSB first per field: op, addr, then wdata
	always_ff @(posedge clk)
	begin
		if ((state == st_idle) && start)
			frame_sr <= {cur_cmd.wdata, cur_cmd.addr, cur_cmd.op};
		else if (shift_en)
			frame_sr <= frame_sr >> 1;
	end

endmodule

// File: src/serial_bus_top.sv
// top level, command registers, master ports and slave on one serial link
`timescale 1ns/10ps

module serial_bus_top
	import bus_pkg::*, host_pkg::*;
#(
	parameter int READ_WAIT = 2
)
(
	input  logic      clk,
	input  logic      reset,
	input  host_cmd_t cmd,
	input  logic      cmd_valid,
	output logic      busy,
	output host_rsp_t rsp,
	output logic      rsp_valid
);

	host_cmd_t           cur_cmd;
	logic                start;
	logic                tx_done;
	logic                rx_done;
	logic [DATA_LEN-1:0] rx_data;
	logic                sdo;
	logic                master_valid;
	logic                master_ready;
	bus_m2s_t            m2s;
	bus_s2m_t            s2m;

	// master line gathered from both ports
	assign m2s = '{sdo: sdo, master_valid: master_valid, master_ready: master_ready};

	master_cmd_regs cmd_regs_i
	(
		.clk       (clk),
		.reset     (reset),
		.cmd       (cmd),
		.cmd_valid (cmd_valid),
		.tx_done   (tx_done),
		.rx_done   (rx_done),
		.rx_data   (rx_data),
		.cur_cmd   (cur_cmd),
		.start     (start),
		.busy      (busy),
		.rsp       (rsp),
		.rsp_valid (rsp_valid)
	);

	master_out_port out_port_i
	(
		.clk          (clk),
		.reset        (reset),
		.cur_cmd      (cur_cmd),
		.start        (start),
		.s2m          (s2m),
		.sdo          (sdo),
		.master_valid (master_valid),
		.tx_done      (tx_done)
	);

	master_in_port in_port_i
	(
		.clk          (clk),
		.reset        (reset),
		.cur_cmd      (cur_cmd),
		.tx_done      (tx_done),
		.s2m          (s2m),
		.master_ready (master_ready),
		.data         (rx_data),
		.rx_done      (rx_done)
	);

	slave_port #(
		.READ_WAIT (READ_WAIT)
	) slave_i
	(
		.clk   (clk),
		.reset (reset),
		.m2s   (m2s),
		.s2m   (s2m)
	);

endmodule

// File: src/slave_port.sv
// slave port FSM, frame decoder, byte memory and read data serializer
`timescale 1ns/10ps

module slave_port
	import bus_pkg::*;
#(
	// idle cycles before read data, at least 1
	parameter int READ_WAIT = 2
)
(
	input  logic     clk,
	input  logic     reset,
	input  bus_m2s_t m2s,
	output bus_s2m_t s2m
);

	localparam int CNT_W = $clog2(ADDR_LEN + DATA_LEN + READ_WAIT + 1);

	typedef enum logic [2:0]
	{
		st_idle,
		st_op,
		st_addr,
		st_data,
		st_wait,
		st_send
	} state_e;

	state_e              state;
	logic [CNT_W-1:0]    cnt;
	logic                slave_valid;
	logic [1:0]          op_sr;
	logic [ADDR_LEN-1:0] addr_sr;
	logic [DATA_LEN-1:0] wdata_sr;
	logic [DATA_LEN-1:0] rdata_sr;
	logic                mem_we;
	logic                rd_load;
	logic                rd_shift;
	// byte array, zero at power up
	logic [DATA_LEN-1:0] mem [0:(1 << ADDR_LEN) - 1] = '{default: '0};

	// ready only when no frame is in progress
	assign s2m = '{sdi: rdata_sr[0], slave_valid: slave_valid,
		slave_ready: (state == st_idle)};

	// write on the cycle after the last data bit
	assign mem_we = (state == st_data) && (cnt == CNT_W'(DATA_LEN));
	assign rd_load = (state == st_wait) && (cnt == CNT_W'(READ_WAIT - 1));
	// hold bit 0 until the master takes it
	assign rd_shift = (state == st_send) && ((cnt != '0) || m2s.master_ready);

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state       <= st_idle;
			cnt         <= '0;
			slave_valid <= 1'b0;
		end
		else
		begin
			case (state)
				st_idle:
				begin
					// opcode bit 0 taken on this edge
					if (m2s.master_valid)
						state <= st_op;
				end
				st_op:
				begin
					cnt   <= '0;
					state <= st_addr;
				end
				st_addr:
				begin
					if (cnt == CNT_W'(ADDR_LEN - 1))
					begin
						cnt <= '0;
						if (op_sr == op_write)
							state <= st_data;
						else if (op_sr == op_read)
							state <= st_wait;
						else
							state <= st_idle;
					end
					else
						cnt <= cnt + 1'b1;
				end
				st_data:
				begin
					// one extra count for the memory write
					if (mem_we)
					begin
						cnt   <= '0;
						state <= st_idle;
					end
					else
						cnt <= cnt + 1'b1;
				end
				st_wait:
				begin
					if (rd_load)
					begin
						cnt         <= '0;
						slave_valid <= 1'b1;
						state       <= st_send;
					end
					else
						cnt <= cnt + 1'b1;
				end
				st_send:
				begin
					if (cnt == CNT_W'(DATA_LEN - 1))
					begin
						// last read bit leaves on this edge
						cnt         <= '0;
						slave_valid <= 1'b0;
						state       <= st_idle;
					end
					else if (rd_shift)
						cnt <= cnt + 1'b1;
				end
				default:
					state <= st_idle;
			endcase
		end
	end

	// field shifters, each filled LSB first from the top
	always_ff @(posedge clk)
	begin
		if (((state == st_idle) && m2s.master_valid) || (state == st_op))
			op_sr <= {m2s.sdo, op_sr[1]};
		if (state == st_addr)
			addr_sr <= {m2s.sdo, addr_sr[ADDR_LEN-1:1]};
		if ((state == st_data) && !mem_we)
			wdata_sr <= {m2s.sdo, wdata_sr[DATA_LEN-1:1]};
		if (rd_load)
			rdata_sr <= mem[addr_sr];
		else if (rd_shift)
			rdata_sr <= rdata_sr >> 1;
	end

	always_ff @(posedge clk)
	begin
		if (mem_we)
			mem[addr_sr] <= wdata_sr;
	end

endmodule

// File: tb/serial_bus_tb.sv
// serial bus testbench with clock, reset, trace stimulus, reference memory, checks and timeout
`timescale 1ns/10ps

module serial_bus_tb
	import bus_pkg::*, host_pkg::*;
();

	localparam int READ_WAIT = 2;
	localparam int MAX_CMDS = 64;
	localparam int FIELDS = 5;
	// cycle budget for one command, doubled for the whole run
	localparam int CMD_CYCLES = WR_FRAME_LEN + DATA_LEN + READ_WAIT + 8 + 10;

	logic      clk;
	logic      reset;
	host_cmd_t cmd;
	logic      cmd_valid;
	logic      busy;
	host_rsp_t rsp;
	logic      rsp_valid;

	// five hex fields per command, unknown past the end of the trace
	logic [15:0]         trace_mem [0:MAX_CMDS*FIELDS-1];
	logic [DATA_LEN-1:0] ref_mem [0:(1 << ADDR_LEN) - 1];
	logic [15:0]         lfsr_state;
	int                  num_cmds = 0;
	int                  cycle_cnt = 0;
	int                  cycle_limit = 0;
	int                  value_errors = 0;
	int                  other_errors = 0;
	int                  rsp_total = 0;
	int                  accepted = 0;

	serial_bus_top #(
		.READ_WAIT (READ_WAIT)
	) dut_i
	(
		.clk       (clk),
		.reset     (reset),
		.cmd       (cmd),
		.cmd_valid (cmd_valid),
		.busy      (busy),
		.rsp       (rsp),
		.rsp_valid (rsp_valid)
	);

	// 40 ns period
	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// every response pulse, compared with accepted commands at the end
	always @(negedge clk)
	begin
		if (!reset && rsp_valid)
			rsp_total++;
	end

	// run limit in cycles
	always @(posedge clk)
	begin
		cycle_cnt++;
		if ((cycle_limit > 0) && (cycle_cnt > cycle_limit))
		begin
			other_errors++;
			$display("run hung, no response after %0d cycles", cycle_cnt);
			$display("errors: %0d value, %0d other", value_errors, other_errors);
			$display("test failed");
			$finish;
		end
	end

	// x^16 + x^14 + x^13 + x^11 + 1, new bit enters at the LSB
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		logic fb;
		fb = s[15] ^ s[13] ^ s[12] ^ s[10];
		return {s[14:0], fb};
	endfunction

	// one LFSR step per bit taken
	task automatic rand_bits(input int n, output int val);
		int k;
		val = 0;
		for (k = 0; k < n; k++)
		begin
			lfsr_state = lfsr_next(lfsr_state);
			val = (val << 1) | lfsr_state[0];
		end
	endtask

	task automatic check_rsp(input string name, input host_rsp_t got, input host_rsp_t exp);
		if (got !== exp)
		begin
			value_errors++;
			$display("[FAIL] %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_busy(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			value_errors++;
			$display("[FAIL] %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
		end
	endtask

	initial
	begin
		host_cmd_t           junk;
		host_rsp_t           got;
		host_rsp_t           exp;
		host_rsp_t           exp_trace;
		bus_op_e             op;
		logic [ADDR_LEN-1:0] addr;
		logic [DATA_LEN-1:0] wdata;
		logic [DATA_LEN-1:0] trace_rdata;
		logic [DATA_LEN-1:0] keep;
		logic [1:0]          flags;
		int                  gap;
		int                  junk_data;
		int                  idx;
		int                  base;

		reset = 1'b1;
		cmd = '0;
		cmd_valid = 1'b0;
		lfsr_state = 16'd74;
		for (idx = 0; idx < (1 << ADDR_LEN); idx++)
			ref_mem[idx] = '0;
		$readmemh("tb/serial_bus_trace.txt", trace_mem);
		// a command counts only when all five fields were read
		while ((num_cmds < MAX_CMDS) && ((^trace_mem[num_cmds*FIELDS+FIELDS-1]) !== 1'bx))
			num_cmds++;
		cycle_limit = num_cmds * CMD_CYCLES * 2;

		repeat (2) @(negedge clk);
		reset = 1'b0;
		check_busy("busy", busy, 1'b0);
		check_busy("rsp_valid", rsp_valid, 1'b0);

		for (idx = 0; idx < num_cmds; idx++)
		begin
			base = idx * FIELDS;
			op = bus_op_e'(trace_mem[base][1:0]);
			addr = trace_mem[base+1][ADDR_LEN-1:0];
			wdata = trace_mem[base+2][DATA_LEN-1:0];
			trace_rdata = trace_mem[base+3][DATA_LEN-1:0];
			flags = trace_mem[base+4][1:0];
			// flag bit 1 forces back to back
			if (flags[1])
				gap = 0;
			else
				rand_bits(3, gap);

			// idle stretch, nothing may be busy or respond here
			@(negedge clk);
			repeat (gap)
			begin
				check_busy("busy", busy, 1'b0);
				check_busy("rsp_valid", rsp_valid, 1'b0);
				@(negedge clk);
			end
			check_busy("busy", busy, 1'b0);
			cmd = '{op: op, addr: addr, wdata: wdata};
			cmd_valid = 1'b1;
			@(negedge clk);
			cmd_valid = 1'b0;

			if (op == op_nop)
			begin
				// nop never raises busy
				check_busy("busy", busy, 1'b0);
				check_busy("rsp_valid", rsp_valid, 1'b0);
			end
			else
			begin
				accepted++;
				check_busy("busy", busy, 1'b1);
				if (flags[0])
				begin
					// junk write to the same byte, must be dropped
					keep = (op == op_write) ? wdata : ref_mem[addr];
					rand_bits(DATA_LEN, junk_data);
					junk = '{op: op_write, addr: addr, wdata: junk_data[DATA_LEN-1:0]};
					if (junk.wdata == keep)
						junk.wdata = ~junk.wdata;
					cmd = junk;
					cmd_valid = 1'b1;
					@(negedge clk);
					cmd_valid = 1'b0;
					check_busy("busy", busy, 1'b1);
				end

				do
					@(negedge clk);
				while (!rsp_valid);
				got = rsp;
				// busy still high in the response cycle
				check_busy("busy", busy, 1'b1);

				exp.op = op;
				exp.addr = addr;
				exp.rdata = (op == op_read) ? ref_mem[addr] : '0;
				exp_trace = exp;
				exp_trace.rdata = trace_rdata;
				check_rsp("rsp", got, exp);
				check_rsp("rsp vs trace", got, exp_trace);
				if (op == op_write)
					ref_mem[addr] = wdata;
			end
		end

		// quiet tail, no stray responses
		@(negedge clk);
		repeat (4)
		begin
			check_busy("busy", busy, 1'b0);
			check_busy("rsp_valid", rsp_valid, 1'b0);
			@(negedge clk);
		end
		@(posedge clk);
		if (num_cmds == 0)
		begin
			other_errors++;
			$display("trace file missing or holds no complete command");
		end
		if (rsp_total != accepted)
		begin
			other_errors++;
			$display("saw %0d responses for %0d accepted commands", rsp_total, accepted);
		end
		$display("errors: %0d value, %0d other", value_errors, other_errors);
		if ((value_errors == 0) && (other_errors == 0))
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

// File: tb/serial_bus_trace.txt
// op addr wdata rdata flags, all hex, one command per line, rdata is the expected read byte
// flags bit 0 tries a junk command while busy, bit 1 skips the idle gap before the command
3 123 00 00 0 // never written
2 001 a5 00 0
3 001 00 a5 0
2 800 3c 00 2 // back to back writes
2 555 81 00 2
2 aaa 7e 00 0
3 800 00 3c 2
3 555 00 81 0
3 aaa 00 7e 2
0 fff 55 00 0 // nop, no line traffic
3 fff 00 00 0
2 0f0 c3 00 1 // junk while busy
3 0f0 00 c3 0
3 00f 00 00 1
3 00f 00 00 2
0 000 ff 00 2
2 fff 01 00 0
3 fff 00 01 2
3 001 00 a5 0

// File: vlog.f
src/bus_pkg.sv
src/host_pkg.sv
src/master_cmd_regs.sv
src/master_out_port.sv
src/master_in_port.sv
src/slave_port.sv
src/serial_bus_top.sv
tb/serial_bus_tb.sv
